/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_audio_udp_top -f verilog.f -o sim_tb
	./obj_dir/sim_tb | tee /dev/stderr | grep "NO ERRORS" > /dev/null

clean:
	rm -rf obj_dir

/* audio_pkg.sv */
`default_nettype none

// ********************
// audio side types
// ********************

package audio_pkg;

   // one pmod sample as it arrives
   typedef logic [15:0] sample_t;

   // packet store word
   // first sample of the pair sits in the upper half
   typedef logic [31:0] pay_word_t;

endpackage

`default_nettype wire

/* audio_sample_packer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "udp_defs.svh"

module audio_sample_packer (
   input  wire                eth_tx_clk,   // gmii tx clock
   input  wire                arst_n,
   input  wire audio_pkg::sample_t audio_data,
   input  wire                audio_en,     // one cycle per sample
   input  wire                pay_ready,
   output logic               pay_valid,
   output net_pkg::byte_t     pay_byte,
   output logic               pay_last,
   output logic               overrun       // sticky until reset
);

   localparam int unsigned spp    = `SAMPLES_PER_PKT;
   localparam int unsigned words  = spp / 2;        // words per buffer
   localparam int unsigned nbytes = 2 * spp;        // payload bytes per packet
   localparam int unsigned sw     = $clog2(spp);    // sample count and store index
   localparam int unsigned bw     = $clog2(nbytes);

   audio_pkg::pay_word_t pkt_mem [0:2*words-1];      // two packet buffers
   audio_pkg::sample_t   hi_sample;                  // even sample waiting for its pair
   audio_pkg::pay_word_t rd_word;

   logic [1:0]    buf_full;                          // one flag per buffer
   logic          wr_buf;                            // buffer being filled
   logic          rd_buf;                            // buffer being sent
   logic          dropping;                          // current packet is thrown away
   logic [sw-1:0] wr_cnt;                            // sample within packet
   logic [bw-1:0] rd_cnt;                            // byte within packet
   logic [sw-1:0] wr_idx;
   logic [sw-1:0] rd_idx;
   logic          first_smp;
   logic          wr_last;
   logic          skip;
   logic          rd_fire;

   assign first_smp = (wr_cnt == '0);
   assign wr_last   = (wr_cnt == sw'(spp - 1));
   assign skip      = first_smp ? buf_full[wr_buf] : dropping;   // drop decided on first sample
   assign rd_fire   = pay_valid & pay_ready;

   assign wr_idx = sw'(wr_buf * words + (wr_cnt >> 1));
   assign rd_idx = sw'(rd_buf * words + (rd_cnt >> 2));

   // ********************
   // write side
   // ********************

   always_ff @(posedge eth_tx_clk) begin
      if (audio_en && !skip) begin
         if (!wr_cnt[0]) begin
            hi_sample <= audio_data;                         // hold upper half
         end else begin
            pkt_mem[wr_idx] <= {hi_sample, audio_data};      // pair complete
         end
      end
   end

   always_ff @(posedge eth_tx_clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_cnt   <= '0;
         wr_buf   <= 1'b0;
         rd_buf   <= 1'b0;
         rd_cnt   <= '0;
         dropping <= 1'b0;
         overrun  <= 1'b0;
         buf_full <= '0;
      end else begin
         if (audio_en) begin
            wr_cnt <= wr_last ? '0 : wr_cnt + 1'b1;
            if (first_smp) begin
               dropping <= buf_full[wr_buf];                // no free buffer left
               overrun  <= overrun | buf_full[wr_buf];
            end
            if (wr_last && !skip) begin
               buf_full[wr_buf] <= 1'b1;                    // packet ready to send
               wr_buf           <= ~wr_buf;
            end
         end
         // ********************
         // read side
         // ********************
         if (rd_fire) begin
            rd_cnt <= pay_last ? '0 : rd_cnt + 1'b1;
            if (pay_last) begin
               buf_full[rd_buf] <= 1'b0;                    // free on next cycle
               rd_buf           <= ~rd_buf;
            end
         end
      end
   end

   assign rd_word   = pkt_mem[rd_idx];
   assign pay_byte  = rd_word[(3 - rd_cnt[1:0]) * 8 +: 8];  // big endian within word
   assign pay_valid = buf_full[rd_buf];
   assign pay_last  = (rd_cnt == bw'(nbytes - 1));

endmodule

`default_nettype wire

/* audio_udp_golden.txt */
# kind then fields: T name | Q idle cycles | S (gap sample) x8 | H header hex | P payload hex
# R count frames: count back-to-back random samples, expected frames, overrun expected
T reset
Q 50
T single
S 3 1234 5 5678 0 9abc 7 def0 2 0f1e 9 2d3c 1 4b5a 4 6978
H 84a938bfc9a0a0b1c2d3e1e108004500002c0000400040119b97c0a8010ba9fe337804d204d200180000
P 123456789abcdef00f1e2d3c4b5a6978
T idcsum
S 4 a001 6 a002 3 a003 8 a004 5 a005 7 a006 4 a007 6 a008
S 5 b101 8 b202 9 b303 6 b404 6 b505 9 b606 7 b707 8 b808
S 6 c0de 4 face 5 beef 3 cafe 8 0001 4 8000 6 7fff 5 ffff
H 84a938bfc9a0a0b1c2d3e1e108004500002c0000400040119b97c0a8010ba9fe337804d204d200180000
P a001a002a003a004a005a006a007a008
H 84a938bfc9a0a0b1c2d3e1e108004500002c0001400040119b96c0a8010ba9fe337804d204d200180000
P b101b202b303b404b505b606b707b808
H 84a938bfc9a0a0b1c2d3e1e108004500002c0002400040119b95c0a8010ba9fe337804d204d200180000
P c0defacebeefcafe000180007fffffff
T overrun
R 64 2

/* audio_udp_top.sv */
`timescale 1ns/1ns
`default_nettype none

module audio_udp_top (
   input  wire            eth_tx_clk,       // gmii tx clock, samples already in this domain
   input  wire            arst_n,
   input  wire audio_pkg::sample_t audio_data,
   input  wire            audio_en,
   output logic           gmii_tx_en,
   output net_pkg::byte_t gmii_txd,
   output logic           overrun
);

   // ********************
   // internal streams
   // ********************

   logic           pay_valid;               // packer to sender
   logic           pay_ready;
   net_pkg::byte_t pay_byte;
   logic           pay_last;

   logic           hdr_valid;               // header gen to sender
   logic           hdr_ready;
   net_pkg::byte_t hdr_byte;
   logic           hdr_last;

   audio_sample_packer u_packer (
      .eth_tx_clk (eth_tx_clk),
      .arst_n     (arst_n),
      .audio_data (audio_data),
      .audio_en   (audio_en),
      .pay_ready  (pay_ready),
      .pay_valid  (pay_valid),
      .pay_byte   (pay_byte),
      .pay_last   (pay_last),
      .overrun    (overrun)
   );

   udp_header_gen u_hdr_gen (
      .eth_tx_clk (eth_tx_clk),
      .arst_n     (arst_n),
      .hdr_ready  (hdr_ready),
      .hdr_valid  (hdr_valid),
      .hdr_byte   (hdr_byte),
      .hdr_last   (hdr_last)
   );

   udp_frame_tx u_frame_tx (
      .eth_tx_clk (eth_tx_clk),
      .arst_n     (arst_n),
      .hdr_valid  (hdr_valid),
      .hdr_byte   (hdr_byte),
      .hdr_last   (hdr_last),
      .pay_valid  (pay_valid),
      .pay_byte   (pay_byte),
      .pay_last   (pay_last),
      .hdr_ready  (hdr_ready),
      .pay_ready  (pay_ready),
      .gmii_tx_en (gmii_tx_en),         // to mac, which adds preamble and fcs
      .gmii_txd   (gmii_txd)
   );

endmodule

`default_nettype wire

/* net_pkg.sv */
`default_nettype none

// ********************
// network side types
// ********************

package net_pkg;

   typedef logic [7:0]  byte_t;             // one gmii byte
   typedef logic [47:0] mac_t;              // ethernet address
   typedef logic [31:0] ip_t;               // ipv4 address
   typedef logic [15:0] len_t;              // ip or udp length field
   typedef logic [15:0] csum_t;             // ipv4 header checksum

   // frame sender states
   typedef enum logic [1:0] {
      IDLE,                                 // wait for header and packet
      HDR,                                  // header bytes on the wire
      PAY,                                  // payload bytes on the wire
      GAP                                   // inter-frame gap
   } tx_state_t;

endpackage

`default_nettype wire

/* tb_audio_udp_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "udp_defs.svh"

module tb_audio_udp_top;

   localparam int spp = `SAMPLES_PER_PKT;
   localparam int hb  = `HDR_BYTES;
   localparam int fb  = hb + 2 * spp;                // bytes per frame

   logic               clk;
   logic               arst_n;
   logic               rst_req;
   audio_pkg::sample_t audio_data;
   logic               audio_en;
   logic               gmii_tx_en;
   net_pkg::byte_t     gmii_txd;
   logic               overrun;

   logic [fb*8-1:0]    rx_q [$];                     // frames seen on gmii
   logic [fb*8-1:0]    exp_q [$];                    // frames from golden file
   audio_pkg::sample_t drv_q [$];                    // random samples in drive order
   logic [fb*8-1:0]    cur_frame;
   logic [hb*8-1:0]    exp_hdr;
   logic [2*spp*8-1:0] exp_pay;
   logic [8*16-1:0]    tname;
   logic [8*128-1:0]   skip_line;
   logic [7:0]         kind;                         // record type letter
   logic [31:0]        rnd = 32'h40641f3c;
   logic               test_on = 1'b0;
   logic               rnd_test = 1'b0;
   int                 fd;
   int                 r;
   int                 n;
   int                 nfr;
   int                 rx_len = 0;
   int                 low_cnt = 0;                  // idle cycles before a frame
   int                 want_frames = 0;
   int                 pkt_cnt = 0;                  // golden packets so far
   int                 cycles = 0;
   int                 err_cnt = 0;
   int                 check_cnt = 0;
   int                 test_cnt = 0;
   int                 test_errs = 0;

   tb_clock_gen clk_gen (.rst_req(rst_req), .clk(clk), .arst_n(arst_n));

   audio_udp_top uut (
      .eth_tx_clk (clk),
      .arst_n     (arst_n),
      .audio_data (audio_data),
      .audio_en   (audio_en),
      .gmii_tx_en (gmii_tx_en),
      .gmii_txd   (gmii_txd),
      .overrun    (overrun)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [7:0] frame_byte(input logic [fb*8-1:0] f, input int i);
      return f[(fb - 1 - i) * 8 +: 8];              // byte 0 is the first on the wire
   endfunction

   task automatic compare(input logic [63:0] act, input logic [63:0] exp, input string what);
      check_cnt++;
      if (act !== exp) begin
         err_cnt++;
         $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, what, act, exp);
      end
   endtask

   // ********************
   // gmii monitor
   // ********************

   always @(negedge clk) begin
      if (gmii_tx_en) begin
         if (rx_len == 0) compare(low_cnt >= `IFG_CYCLES, 1, "idle gap before frame");
         if (rx_len < fb) cur_frame[(fb - 1 - rx_len) * 8 +: 8] = gmii_txd;
         rx_len++;
         low_cnt = 0;
      end else begin
         if (rx_len != 0) begin                      // frame just ended
            compare(rx_len, fb, "frame length in bytes");
            rx_q.push_back(cur_frame);
            rx_len = 0;
         end
         if (low_cnt < 1000) low_cnt++;
      end
   end

   // ********************
   // test steps
   // ********************

   task automatic start_test();
      rx_q.delete();
      exp_q.delete();
      drv_q.delete();
      want_frames = 0;
      rnd_test = 1'b0;
      test_on = 1'b1;
      test_errs = err_cnt;
      rst_req = 1'b1;                                // reset again so id restarts at 0
      @(negedge clk);
      rst_req = 1'b0;
      while (!arst_n) @(negedge clk);
   endtask

   task automatic hold_quiet(input int count);
      repeat (count) begin
         @(negedge clk);
         compare(gmii_tx_en, 1'b0, "gmii_tx_en low with no samples");
         compare(overrun, 1'b0, "overrun low with no samples");
      end
   endtask

   task automatic drive_packet();
      int k;
      int gap;
      logic [15:0] smp;
      for (k = 0; k < spp; k++) begin
         r = $fscanf(fd, " %d %h", gap, smp);
         repeat (gap) @(negedge clk);
         audio_data = smp;
         audio_en = 1'b1;
         @(negedge clk);
         audio_en = 1'b0;
      end
      pkt_cnt++;
   endtask

   task automatic drive_random(input int count);
      int k;
      for (k = 0; k < count; k++) begin
         rnd = lcg_next(rnd);
         audio_data = rnd[31:16];                    // upper lcg bits spread better
         audio_en = 1'b1;
         drv_q.push_back(rnd[31:16]);
         @(negedge clk);
      end
      audio_en = 1'b0;
      pkt_cnt += count / spp;
      rnd_test = 1'b1;
   endtask

   task automatic finish_test();
      int i;
      int k;
      int b;
      int g;
      int last_g;
      logic found;
      logic match;
      if (test_on) begin
         while (rx_q.size() < want_frames) @(negedge clk);
         repeat (2 * (fb + `IFG_CYCLES)) @(negedge clk);   // room for a stray extra frame
         compare(rx_q.size(), want_frames, "frame count");
         compare(overrun, rnd_test, "overrun flag");
         last_g = -1;
         for (i = 0; i < want_frames; i++) begin
            if (rnd_test) begin
               compare({frame_byte(rx_q[i], 18), frame_byte(rx_q[i], 19)}, i, "identification");
               g = last_g + 1;
               found = 1'b0;
               while (!found && (g + 1) * spp <= drv_q.size()) begin
                  match = 1'b1;
                  for (k = 0; k < spp; k++) begin
                     if ({frame_byte(rx_q[i], hb + 2 * k), frame_byte(rx_q[i], hb + 2 * k + 1)}
                         != drv_q[g * spp + k]) match = 1'b0;
                  end
                  if (match) found = 1'b1;
                  else g++;
               end
               compare(found, 1'b1, $sformatf("frame %0d payload is a later sample group", i));
               last_g = g;
            end else begin
               for (b = 0; b < fb; b++) begin
                  compare(frame_byte(rx_q[i], b), frame_byte(exp_q[i], b),
                          $sformatf("frame %0d byte %0d", i, b));
               end
            end
         end
         $display("test %0s done, %0d mismatches", tname, err_cnt - test_errs);
         test_cnt++;
      end
   endtask

   // ********************
   // golden file driver
   // ********************

   initial begin : main
      rst_req = 1'b0;
      audio_en = 1'b0;
      audio_data = '0;
      fd = $fopen("audio_udp_golden.txt", "r");
      if (fd == 0) begin
         $display("golden file audio_udp_golden.txt could not be opened");
         err_cnt++;
      end else begin
         while ($fscanf(fd, " %s", kind) == 1) begin
            case (kind)
               "#": r = $fgets(skip_line, fd);      // column notes
               "T": begin
                  finish_test();
                  r = $fscanf(fd, " %s", tname);
                  start_test();
               end
               "Q": begin
                  r = $fscanf(fd, " %d", n);
                  hold_quiet(n);
               end
               "S": drive_packet();
               "H": r = $fscanf(fd, " %h", exp_hdr);
               "P": begin
                  r = $fscanf(fd, " %h", exp_pay);
                  exp_q.push_back({exp_hdr, exp_pay});
                  want_frames++;
               end
               "R": begin
                  r = $fscanf(fd, " %d %d", n, nfr);
                  want_frames += nfr;
                  drive_random(n);
               end
               default: begin
                  $display("unknown record type %c in golden file", kind);
                  err_cnt++;
               end
            endcase
         end
         $fclose(fd);
      end
      finish_test();
      $display("%0d tests, %0d checks, %0d failures", test_cnt, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   initial begin : watchdog
      while (cycles <= 2000 + 200 * pkt_cnt) begin   // limit grows with each packet
         @(posedge clk);
         cycles++;
      end
      $display("timeout, run still busy after %0d cycles", cycles);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
   input  wire  rst_req,                    // pulse to reset again between tests
   output logic clk,
   output logic arst_n
);

   initial clk = 1'b0;
   always #5 clk = ~clk;                    // 10 ns period

   always begin
      arst_n = 1'b0;
      repeat (10) @(posedge clk);           // hold for 10 cycles
      @(negedge clk);
      arst_n = 1'b1;                        // release away from the active edge
      @(posedge rst_req);
   end

endmodule

`default_nettype wire

/* udp_defs.svh */
`ifndef UDP_DEFS_SVH
`define UDP_DEFS_SVH

// ********************
// station addresses
// ********************

`define BOARD_MAC 48'ha0_b1_c2_d3_e1_e1     // board mac
`define DES_MAC   48'h84_a9_38_bf_c9_a0     // pc mac
`define BOARD_IP  32'hc0_a8_01_0b           // 192.168.1.11
`define DES_IP    32'ha9_fe_33_78           // 169.254.51.120

// ********************
// udp ports
// ********************

`define UDP_SRC_PORT 16'd1234               // board side port
`define UDP_DST_PORT 16'd1234               // pc listens here

// ********************
// framing
// ********************

`define SAMPLES_PER_PKT 8                   // keep even, two samples per word
`define HDR_BYTES       42                  // eth 14 + ip 20 + udp 8
`define IFG_CYCLES      12                  // idle bytes after each frame

`endif

/* udp_frame_tx.sv */
`timescale 1ns/1ns
`default_nettype none
`include "udp_defs.svh"

module udp_frame_tx (
   input  wire            eth_tx_clk,       // gmii tx clock
   input  wire            arst_n,
   input  wire            hdr_valid,
   input  wire net_pkg::byte_t hdr_byte,
   input  wire            hdr_last,
   input  wire            pay_valid,
   input  wire net_pkg::byte_t pay_byte,
   input  wire            pay_last,
   output logic           hdr_ready,
   output logic           pay_ready,
   output logic           gmii_tx_en,
   output net_pkg::byte_t gmii_txd
);

   localparam int unsigned ifg = `IFG_CYCLES;
   localparam int unsigned gw  = $clog2(ifg);

   net_pkg::tx_state_t state;
   logic [gw-1:0]      gap_cnt;             // cycles spent in gap
   logic               hdr_fire;
   logic               pay_fire;

   // ready only while that stream owns the wire
   assign hdr_ready = (state == net_pkg::HDR);
   assign pay_ready = (state == net_pkg::PAY);
   assign hdr_fire  = hdr_valid & hdr_ready;
   assign pay_fire  = pay_valid & pay_ready;

   // ********************
   // frame fsm
   // ********************

   always_ff @(posedge eth_tx_clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= net_pkg::IDLE;
         gap_cnt <= '0;
      end else begin
         case (state)
            net_pkg::IDLE: begin
               if (hdr_valid && pay_valid) begin      // both halves of a frame ready
                  state <= net_pkg::HDR;
               end
            end
            net_pkg::HDR: begin
               if (hdr_fire && hdr_last) begin
                  state <= net_pkg::PAY;              // payload follows back to back
               end
            end
            net_pkg::PAY: begin
               if (pay_fire && pay_last) begin
                  state   <= net_pkg::GAP;
                  gap_cnt <= '0;
               end
            end
            net_pkg::GAP: begin
               if (gap_cnt == gw'(ifg - 1)) begin
                  state <= net_pkg::IDLE;
               end else begin
                  gap_cnt <= gap_cnt + 1'b1;
               end
            end
            default: state <= net_pkg::IDLE;
         endcase
      end
   end

   // ********************
   // gmii output
   // ********************

   always_ff @(posedge eth_tx_clk or negedge arst_n) begin
      if (!arst_n) begin
         gmii_tx_en <= 1'b0;
      end else begin
         gmii_tx_en <= hdr_fire | pay_fire;   // one byte per accepted cycle
      end
   end

   always_ff @(posedge eth_tx_clk) begin
      if (hdr_fire) begin
         gmii_txd <= hdr_byte;
      end else if (pay_fire) begin
         gmii_txd <= pay_byte;
      end
   end

endmodule

`default_nettype wire

/* udp_header_gen.sv */
`timescale 1ns/1ns
`default_nettype none
`include "udp_defs.svh"

module udp_header_gen (
   input  wire            eth_tx_clk,       // gmii tx clock
   input  wire            arst_n,
   input  wire            hdr_ready,
   output logic           hdr_valid,        // checksum done, bytes available
   output net_pkg::byte_t hdr_byte,
   output logic           hdr_last
);

   localparam int unsigned hb = `HDR_BYTES;
   localparam int unsigned iw = $clog2(hb);

   localparam net_pkg::mac_t src_mac = `BOARD_MAC;
   localparam net_pkg::mac_t dst_mac = `DES_MAC;
   localparam net_pkg::ip_t  src_ip  = `BOARD_IP;
   localparam net_pkg::ip_t  dst_ip  = `DES_IP;
   localparam net_pkg::len_t ip_len  = 16'(28 + 2 * `SAMPLES_PER_PKT);   // ip hdr + udp hdr + data
   localparam net_pkg::len_t udp_len = 16'(8 + 2 * `SAMPLES_PER_PKT);

   logic [15:0]      ip_id;                 // identification, one per frame
   logic             busy;                  // checksum in progress
   logic [3:0]       word_idx;              // ip header word being summed
   logic [15:0]      word;
   logic [15:0]      acc;                   // running ones' complement sum
   logic [16:0]      sum;
   logic [15:0]      acc_next;
   net_pkg::csum_t   csum;
   logic [iw-1:0]    byte_idx;              // next header byte to send
   logic [hb*8-1:0]  hdr_vec;
   logic             hdr_fire;

   // ********************
   // checksum datapath
   // ********************

   always_comb begin
      case (word_idx)
         4'd0:    word = 16'h4500;          // version, ihl, tos
         4'd1:    word = ip_len;
         4'd2:    word = ip_id;
         4'd3:    word = 16'h4000;          // dont fragment
         4'd4:    word = {8'd64, 8'd17};    // ttl, udp
         4'd6:    word = src_ip[31:16];
         4'd7:    word = src_ip[15:0];
         4'd8:    word = dst_ip[31:16];
         4'd9:    word = dst_ip[15:0];
         default: word = 16'h0000;          // checksum field itself
      endcase
   end

   assign sum      = {1'b0, acc} + {1'b0, word};
   assign acc_next = sum[15:0] + {15'd0, sum[16]};          // end-around carry
   assign hdr_fire = hdr_valid & hdr_ready;

   always_ff @(posedge eth_tx_clk or negedge arst_n) begin
      if (!arst_n) begin
         busy      <= 1'b1;                 // first header computed right away
         word_idx  <= '0;
         acc       <= '0;
         csum      <= '0;
         hdr_valid <= 1'b0;
         ip_id     <= '0;
         byte_idx  <= '0;
      end else if (busy) begin
         acc      <= acc_next;
         word_idx <= word_idx + 1'b1;
         if (word_idx == 4'd9) begin
            busy      <= 1'b0;
            csum      <= ~acc_next;
            hdr_valid <= 1'b1;
         end
      end else if (hdr_fire) begin
         if (hdr_last) begin
            hdr_valid <= 1'b0;
            busy      <= 1'b1;              // start next frame's header
            word_idx  <= '0;
            acc       <= '0;
            byte_idx  <= '0;
            ip_id     <= ip_id + 1'b1;
         end else begin
            byte_idx <= byte_idx + 1'b1;
         end
      end
   end

   // ********************
   // byte select
   // ********************

   assign hdr_vec = {dst_mac, src_mac, 16'h0800,                  // ethernet
                     16'h4500, ip_len, ip_id, 16'h4000,
                     8'd64, 8'd17, csum, src_ip, dst_ip,          // ipv4
                     `UDP_SRC_PORT, `UDP_DST_PORT, udp_len,
                     16'h0000};                                   // udp, no checksum

   assign hdr_byte = hdr_vec[(hb - 1 - byte_idx) * 8 +: 8];       // msb goes first
   assign hdr_last = (byte_idx == iw'(hb - 1));

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
audio_pkg.sv
net_pkg.sv
audio_sample_packer.sv
udp_header_gen.sv
udp_frame_tx.sv
audio_udp_top.sv
tb_clock_gen.sv
tb_audio_udp_top.sv
